// ==== src/adc_macros.svh ====
// widths, default settings and settle time shared by the adc controller
`ifndef ADC_MACROS_SVH
`define ADC_MACROS_SVH

// width of every count and run-up setting
`define ADC_COUNT_W 24

// spi frame length in bits
`define ADC_FRAME_W 32

// address byte is complete after this many bits
`define ADC_ADDR_BITS 8

// settle clocks spent in init with switches off
`define ADC_INIT_WAIT 64

// run-up defaults, restored by reset and soft restore
`define ADC_RUNUP_LEN_DEFAULT 20
`define ADC_PHASES_DEFAULT 10

// led pattern after reset or soft restore
`define ADC_LED_DEFAULT 3'b101

`endif

// ==== src/adc_pkg.sv ====
// adc controller types: spi frame union, register map, modulator states
// and integrator switch codes
`include "adc_macros.svh"

package adc_pkg;

  // one spi frame, seen as the shift image or as decoded fields
  typedef union packed {
    logic [`ADC_FRAME_W-1:0] raw;
    struct packed {
      // set to read without writing
      logic                    read_only;
      logic [6:0]              addr;
      logic [`ADC_COUNT_W-1:0] value;
    } fields;
  } spi_frame_u;

  // register map, 7 bit addresses
  typedef enum logic [6:0] {
    REG_LED           = 7'd7,
    REG_RUNUP_LEN     = 7'd8,
    REG_COUNT_UP      = 7'd9,
    REG_COUNT_DOWN    = 7'd10,
    REG_COUNT_RUNDOWN = 7'd11,
    REG_PHASES        = 7'd12,
    REG_RESTORE       = 7'd13
  } reg_addr_e;

  typedef enum logic [2:0] {
    ST_INIT,
    ST_RUNUP,
    ST_RUNDOWN,
    ST_DONE
  } mod_state_e;

  // bit order is {sig, n, p}
  typedef enum logic [2:0] {
    SW_OFF = 3'b000,
    SW_POS = 3'b001,
    SW_NEG = 3'b010
  } switch_e;

endpackage

// ==== src/adc_ctrl_if.sv ====
// settings and results between the spi register bank and the modulator
`timescale 1ns/10ps
`include "adc_macros.svh"

interface adc_ctrl_if;

  // settings, owned by the register bank
  logic [`ADC_COUNT_W-1:0] runup_len;
  logic [`ADC_COUNT_W-1:0] phase_total;

  // latched results, owned by the modulator
  // held until the next result_valid
  logic [`ADC_COUNT_W-1:0] count_up;
  logic [`ADC_COUNT_W-1:0] count_down;
  logic [`ADC_COUNT_W-1:0] count_rundown;
  logic                    result_valid;

  modport regs (
    output runup_len, phase_total,
    input  count_up, count_down, count_rundown, result_valid
  );

  modport modulator (
    input  runup_len, phase_total,
    output count_up, count_down, count_rundown, result_valid
  );

endinterface

// ==== src/spi_register_bank.sv ====
// spi slave register bank, oversampled on clk
// led and run-up settings, read-back of latched conversion counts
`timescale 1ns/10ps
`include "adc_macros.svh"

module spi_register_bank (
  input  logic       clk,
  input  logic       reset,
  input  logic       spi_sclk,
  input  logic       spi_cs,
  input  logic       spi_mosi,
  output logic       spi_miso,
  output logic [2:0] led,
  adc_ctrl_if.regs   ctrl
);

  // two sync flops plus one edge-detect stage per line
  logic [2:0] sclk_s;
  logic [2:0] cs_s;
  logic [1:0] mosi_s;
  logic       sclk_fall;
  logic       cs_rise;

  // frame shift registers and bit count
  adc_pkg::spi_frame_u     rx;
  logic [`ADC_FRAME_W-1:0] rx_next;
  logic [`ADC_FRAME_W-1:0] tx;
  logic [5:0]              bit_cnt;

  // read decode
  adc_pkg::reg_addr_e      rd_addr;
  logic [`ADC_COUNT_W-1:0] rd_value;

  // local copy of the latest result
  logic [`ADC_COUNT_W-1:0] res_up;
  logic [`ADC_COUNT_W-1:0] res_down;
  logic [`ADC_COUNT_W-1:0] res_rundown;

  //////////////////////////////
  // synchronizers

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_s <= 3'b000;
      // cs idles high, so no false frame end out of reset
      cs_s   <= 3'b111;
      mosi_s <= 2'b00;
    end
    else
    begin
      sclk_s <= {sclk_s[1:0], spi_sclk};
      cs_s   <= {cs_s[1:0], spi_cs};
      mosi_s <= {mosi_s[0], spi_mosi};
    end
  end

  assign sclk_fall = (sclk_s[2:1] == 2'b10);
  assign cs_rise   = (cs_s[2:1] == 2'b01);

  //////////////////////////////
  // shift in and out

  // frame image after this falling edge, mosi shifted in msb first
  assign rx_next = {rx.raw[`ADC_FRAME_W-2:0], mosi_s[1]};

  // address is the low 7 bits of the first byte, top bit is read-only
  assign rd_addr = adc_pkg::reg_addr_e'(rx_next[6:0]);

  always_comb
  begin
    case (rd_addr)
      adc_pkg::REG_LED:           rd_value = {{(`ADC_COUNT_W-3){1'b0}}, led};
      adc_pkg::REG_RUNUP_LEN:     rd_value = ctrl.runup_len;
      adc_pkg::REG_COUNT_UP:      rd_value = res_up;
      adc_pkg::REG_COUNT_DOWN:    rd_value = res_down;
      adc_pkg::REG_COUNT_RUNDOWN: rd_value = res_rundown;
      adc_pkg::REG_PHASES:        rd_value = ctrl.phase_total;
      default:                    rd_value = '0;
    endcase
  end

  // rx carries no reset, bit_cnt qualifies it
  always_ff @(posedge clk)
  begin
    if (sclk_fall && !cs_s[1])
      rx.raw <= rx_next;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_cnt <= '0;
      tx      <= '0;
    end
    else if (cs_s[1])
    begin
      // idle or frame end, miso returns low
      bit_cnt <= '0;
      tx      <= '0;
    end
    else if (sclk_fall)
    begin
      // saturate so overlong frames never look like 32 bits
      if (bit_cnt != 6'h3f)
        bit_cnt <= bit_cnt + 6'd1;
      if (bit_cnt == 6'(`ADC_ADDR_BITS - 1))
        // snapshot: value occupies the upper 24 bits from bit 9 on
        tx <= {rd_value, {(`ADC_FRAME_W-`ADC_COUNT_W){1'b0}}};
      else
        tx <= {tx[`ADC_FRAME_W-2:0], 1'b0};
    end
  end

  assign spi_miso = tx[`ADC_FRAME_W-1];

  //////////////////////////////
  // writable registers

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      led             <= `ADC_LED_DEFAULT;
      ctrl.runup_len   <= `ADC_COUNT_W'(`ADC_RUNUP_LEN_DEFAULT);
      ctrl.phase_total <= `ADC_COUNT_W'(`ADC_PHASES_DEFAULT);
    end
    else if (cs_rise && bit_cnt == 6'(`ADC_FRAME_W) && !rx.fields.read_only)
    begin
      case (adc_pkg::reg_addr_e'(rx.fields.addr))
        adc_pkg::REG_LED:       led <= rx.fields.value[2:0];
        adc_pkg::REG_RUNUP_LEN: ctrl.runup_len <= rx.fields.value;
        adc_pkg::REG_PHASES:    ctrl.phase_total <= rx.fields.value;
        adc_pkg::REG_RESTORE:
        begin
          // soft restore, value bits ignored
          led             <= `ADC_LED_DEFAULT;
          ctrl.runup_len   <= `ADC_COUNT_W'(`ADC_RUNUP_LEN_DEFAULT);
          ctrl.phase_total <= `ADC_COUNT_W'(`ADC_PHASES_DEFAULT);
        end
        // count registers are read only
        default: ;
      endcase
    end
  end

  // result copy, taken on the modulator strobe
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      res_up      <= '0;
      res_down    <= '0;
      res_rundown <= '0;
    end
    else if (ctrl.result_valid)
    begin
      res_up      <= ctrl.count_up;
      res_down    <= ctrl.count_down;
      res_rundown <= ctrl.count_rundown;
    end
  end

endmodule

// ==== src/multislope_modulator.sv ====
// multislope run-up/run-down modulator
// comparator synchronizer, phase counters and result latch
`timescale 1ns/10ps
`include "adc_macros.svh"

module multislope_modulator (
  input  logic          clk,
  input  logic          reset,
  input  logic          cmpr_out,
  output logic [2:0]    switches,
  output logic          cmpr_latch,
  output logic          com_interrupt,
  adc_ctrl_if.modulator ctrl
);

  // comparator, two sync flops plus edge stage
  logic [2:0] cmpr_s;
  logic       cmpr_high;
  logic       cmpr_cross;

  adc_pkg::mod_state_e state;
  adc_pkg::switch_e    sw;
  adc_pkg::switch_e    next_sw;

  // clocks within the current phase or init wait
  logic [`ADC_COUNT_W-1:0] clk_cnt;
  // phases started so far in this run-up
  logic [`ADC_COUNT_W-1:0] phase_cnt;

  // settings, frozen for one conversion
  logic [`ADC_COUNT_W-1:0] runup_len_q;
  logic [`ADC_COUNT_W-1:0] phase_total_q;

  // running counts of the conversion in progress
  logic [`ADC_COUNT_W-1:0] up_acc;
  logic [`ADC_COUNT_W-1:0] down_acc;
  logic [`ADC_COUNT_W-1:0] rundown_acc;

  logic init_done;
  logic phase_end;

  //////////////////////////////
  // comparator sync

  always_ff @(posedge clk)
  begin
    if (reset)
      cmpr_s <= 3'b000;
    else
      cmpr_s <= {cmpr_s[1:0], cmpr_out};
  end

  assign cmpr_high  = cmpr_s[1];
  // either direction of zero crossing
  assign cmpr_cross = cmpr_s[2] ^ cmpr_s[1];

  // integrator above zero, so pull it down with the negative reference
  assign next_sw   = cmpr_high ? adc_pkg::SW_NEG : adc_pkg::SW_POS;
  assign init_done = (clk_cnt == `ADC_COUNT_W'(`ADC_INIT_WAIT - 1));
  assign phase_end = (clk_cnt == runup_len_q - `ADC_COUNT_W'(1));

  // settings sampled only when a conversion starts
  always_ff @(posedge clk)
  begin
    if (state == adc_pkg::ST_INIT && init_done)
    begin
      runup_len_q   <= ctrl.runup_len;
      phase_total_q <= ctrl.phase_total;
    end
  end

  //////////////////////////////
  // conversion fsm

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state              <= adc_pkg::ST_INIT;
      sw                 <= adc_pkg::SW_OFF;
      cmpr_latch         <= 1'b1;
      com_interrupt      <= 1'b1;
      clk_cnt            <= '0;
      phase_cnt          <= '0;
      up_acc             <= '0;
      down_acc           <= '0;
      rundown_acc        <= '0;
      ctrl.count_up      <= '0;
      ctrl.count_down    <= '0;
      ctrl.count_rundown <= '0;
      ctrl.result_valid  <= 1'b0;
    end
    else
    begin
      clk_cnt <= clk_cnt + `ADC_COUNT_W'(1);
      case (state)
        adc_pkg::ST_INIT:
        begin
          if (init_done)
          begin
            // first phase direction taken straight from the comparator
            state      <= adc_pkg::ST_RUNUP;
            clk_cnt    <= '0;
            phase_cnt  <= `ADC_COUNT_W'(1);
            sw         <= next_sw;
            up_acc     <= `ADC_COUNT_W'(cmpr_high);
            down_acc   <= `ADC_COUNT_W'(!cmpr_high);
            // comparator stays enabled from here on
            cmpr_latch <= 1'b0;
          end
        end

        adc_pkg::ST_RUNUP:
        begin
          if (phase_end)
          begin
            clk_cnt <= '0;
            sw      <= next_sw;
            if (phase_cnt == phase_total_q)
            begin
              // same direction rule, now for the run-down slope
              state       <= adc_pkg::ST_RUNDOWN;
              rundown_acc <= '0;
            end
            else
            begin
              phase_cnt <= phase_cnt + `ADC_COUNT_W'(1);
              if (cmpr_high)
                up_acc <= up_acc + `ADC_COUNT_W'(1);
              else
                down_acc <= down_acc + `ADC_COUNT_W'(1);
            end
          end
        end

        adc_pkg::ST_RUNDOWN:
        begin
          rundown_acc <= rundown_acc + `ADC_COUNT_W'(1);
          if (cmpr_cross)
          begin
            // count includes the crossing clock itself
            state              <= adc_pkg::ST_DONE;
            sw                 <= adc_pkg::SW_OFF;
            com_interrupt      <= 1'b0;
            ctrl.count_up      <= up_acc;
            ctrl.count_down    <= down_acc;
            ctrl.count_rundown <= rundown_acc + `ADC_COUNT_W'(1);
            ctrl.result_valid  <= 1'b1;
          end
        end

        adc_pkg::ST_DONE:
        begin
          // interrupt and strobe last exactly one clock
          state             <= adc_pkg::ST_INIT;
          clk_cnt           <= '0;
          com_interrupt     <= 1'b1;
          ctrl.result_valid <= 1'b0;
        end

        default:
          state <= adc_pkg::ST_INIT;
      endcase
    end
  end

  assign switches = sw;

endmodule

// ==== src/adc_top.sv ====
// adc controller top: spi register bank, multislope modulator
// and the split of the switch code onto the integrator pins
`timescale 1ns/10ps

module adc_top (
  input  logic       clk,
  input  logic       reset,

  // host spi, cs idle high
  input  logic       spi_sclk,
  input  logic       spi_cs,
  input  logic       spi_mosi,
  output logic       spi_miso,

  // comparator
  input  logic       cmpr_out,
  output logic       cmpr_latch,

  // active low, one clk per conversion
  output logic       com_interrupt,

  // integrator input switches
  output logic       int_in_p,
  output logic       int_in_n,
  output logic       int_in_sig,

  output logic [2:0] led
);

  logic [2:0] switches;

  // settings down, results up
  adc_ctrl_if ctrl_if ();

  spi_register_bank i_bank (
    .clk      (clk),
    .reset    (reset),
    .spi_sclk (spi_sclk),
    .spi_cs   (spi_cs),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .led      (led),
    .ctrl     (ctrl_if.regs)
  );

  multislope_modulator i_modulator (
    .clk           (clk),
    .reset         (reset),
    .cmpr_out      (cmpr_out),
    .switches      (switches),
    .cmpr_latch    (cmpr_latch),
    .com_interrupt (com_interrupt),
    .ctrl          (ctrl_if.modulator)
  );

  // switch code is {sig, n, p}
  assign {int_in_sig, int_in_n, int_in_p} = switches;

endmodule

// ==== verification/adc_props.sv ====
// bound concurrent assertions for the multislope modulator
// interrupt pulse shape, switch codes and reset values
`timescale 1ns/10ps

module adc_props (
  input logic       clk,
  input logic       reset,
  input logic       com_interrupt,
  input logic       cmpr_latch,
  input logic [2:0] switches,
  input logic [2:0] state
);

  //////////////////////////////
  // reset behavior

  // outputs settle to their idle values one clk into reset
  a_reset_idle: assert property (
    @(posedge clk) reset |=> (com_interrupt && cmpr_latch && switches == 3'b000)
  ) else $error("outputs not idle after reset");

  // interrupt only ever follows a finished run-down
  // so it stays high from reset until the first run-down ends
  a_int_after_rundown: assert property (
    @(posedge clk) disable iff (reset)
    $fell(com_interrupt) |-> ($past(state) == 3'(adc_pkg::ST_RUNDOWN))
  ) else $error("interrupt without a finished run-down");

  //////////////////////////////
  // pulse width and switch codes

  // low pulse lasts a single clk
  a_int_one_clk: assert property (
    @(posedge clk) disable iff (reset)
    $fell(com_interrupt) |=> com_interrupt
  ) else $error("interrupt low for more than one clk");

  // never both references, never the signal path here
  a_switch_code: assert property (
    @(posedge clk) disable iff (reset)
    switches inside {3'b000, 3'b001, 3'b010}
  ) else $error("illegal integrator switch code");

endmodule

bind multislope_modulator adc_props i_props (
  .clk           (clk),
  .reset         (reset),
  .com_interrupt (com_interrupt),
  .cmpr_latch    (cmpr_latch),
  .switches      (switches),
  .state         (state)
);

// ==== verification/tb_adc_top.sv ====
// testbench for the adc controller: spi host, integrator model,
// register and conversion tests with a cycle limit
`timescale 1ns/10ps

module tb_adc_top;

  // 4 conversions of ~400 clk plus 40 frames of ~270 clk, with margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic       clk;
  logic       reset;
  logic       spi_sclk;
  logic       spi_cs;
  logic       spi_mosi;
  logic       spi_miso;
  logic       cmpr_out;
  logic       cmpr_latch;
  logic       com_interrupt;
  logic       int_in_p;
  logic       int_in_n;
  logic       int_in_sig;
  logic [2:0] led;

  int          cycles;
  int          fail_count;
  int          pass_count;
  bit          test_bad;
  int unsigned seed;
  int          offset;

  // integrator and switch-level model
  int integ;
  bit hold_cmpr;
  int cfg_len;
  int cfg_total;
  int conv_len;
  int conv_total;
  int k;
  int mdl_up;
  int mdl_down;
  int mdl_rundown;
  int lat_up;
  int lat_down;
  int lat_rundown;
  // clocks with the signal switch closed
  int sig_clks;
  // clocks with a reference on while the comparator is latched
  int latch_clks;

  logic [23:0] rd;
  logic [23:0] rd_up;
  logic [23:0] rd_down;
  logic [23:0] rd_rundown;

  adc_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .spi_sclk      (spi_sclk),
    .spi_cs        (spi_cs),
    .spi_mosi      (spi_mosi),
    .spi_miso      (spi_miso),
    .cmpr_out      (cmpr_out),
    .cmpr_latch    (cmpr_latch),
    .com_interrupt (com_interrupt),
    .int_in_p      (int_in_p),
    .int_in_n      (int_in_n),
    .int_in_sig    (int_in_sig),
    .led           (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////////////
  // integrator model

  // sampled at posedge, so registered dut outputs read their settled value
  always @(posedge clk)
  begin
    if (reset)
    begin
      integ = offset;
      k = 0;
    end
    else
    begin
      // +3 on positive ref, -2 on negative ref
      if (int_in_p)
        integ += 3;
      if (int_in_n)
        integ -= 2;
      // signal path never used, comparator enabled while a reference is on
      if (int_in_sig)
        sig_clks++;
      if ((int_in_p || int_in_n) && cmpr_latch)
        latch_clks++;
      // counts of the finished conversion
      if (!com_interrupt)
      begin
        lat_up      = mdl_up;
        lat_down    = mdl_down;
        lat_rundown = mdl_rundown;
      end
      if (!int_in_p && !int_in_n)
      begin
        k = 0;
        mdl_up = 0;
        mdl_down = 0;
        mdl_rundown = 0;
      end
      else
      begin
        if (k == 0)
        begin
          conv_len   = cfg_len;
          conv_total = cfg_total;
        end
        // first clk of each run-up phase decides its direction
        if (k < conv_len * conv_total)
        begin
          if (k % conv_len == 0)
          begin
            if (int_in_n)
              mdl_up++;
            else
              mdl_down++;
          end
        end
        else
          mdl_rundown++;
        k++;
      end
    end
  end

  // comparator is the integrator sign, frozen while held
  always @(negedge clk)
  begin
    if (!hold_cmpr)
      cmpr_out = (integ > 0);
  end

  //////////////////////////////
  // spi host and checks

  // one frame, 8 clk per bit, cut short when nbits < 32
  task automatic spi_frame(input logic [31:0] word, input int nbits,
                           output logic [23:0] value);
    value = '0;
    spi_cs = 1'b0;
    repeat (4) @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      spi_mosi = word[31-i];
      spi_sclk = 1'b1;
      repeat (4) @(negedge clk);
      // bits 9..32 carry the read snapshot
      if (i >= 8)
        value[31-i] = spi_miso;
      spi_sclk = 1'b0;
      repeat (4) @(negedge clk);
    end
    spi_cs = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  task automatic reg_write(input logic [6:0] addr, input logic [23:0] data);
    logic [23:0] unused;
    spi_frame({1'b0, addr, data}, 32, unused);
  endtask

  task automatic reg_read(input logic [6:0] addr, output logic [23:0] data);
    spi_frame({1'b1, addr, 24'd0}, 32, data);
  endtask

  task automatic check_value(input string name, input int exp, input int got);
    assert (exp == got)
    else
    begin
      $display("error %s expected %0d actual %0d", name, exp, got);
      test_bad = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_bad)
      fail_count++;
    else
      pass_count++;
    $display("test %s: %s", name, test_bad ? "failed" : "ok");
    test_bad = 1'b0;
  endtask

  task automatic wait_interrupt();
    @(negedge clk);
    while (com_interrupt)
      @(negedge clk);
  endtask

  initial
  begin
    reset = 1'b1;
    spi_sclk = 1'b0;
    spi_cs = 1'b1;
    spi_mosi = 1'b0;
    cmpr_out = 1'b0;
    hold_cmpr = 1'b0;
    cfg_len = 20;
    cfg_total = 10;
    // start offset from the lcg, never exactly zero
    seed = lcg_next(32'd40);
    offset = int'((seed >> 16) % 41) - 20;
    if (offset == 0)
      offset = 7;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    // defaults after reset
    check_value("reset_defaults cmpr_latch", 1, int'(cmpr_latch));
    reg_read(7'd7, rd);
    check_value("reset_defaults led", 5, int'(rd));
    reg_read(7'd8, rd);
    check_value("reset_defaults runup_len", 20, int'(rd));
    reg_read(7'd12, rd);
    check_value("reset_defaults phases", 10, int'(rd));
    finish_test("reset_defaults");

    // led write, then a read-only frame must not write
    reg_write(7'd7, 24'd3);
    check_value("led_write pins", 3, int'(led));
    reg_read(7'd7, rd);
    check_value("led_write readback", 3, int'(rd));
    reg_read(7'd7, rd);
    check_value("led_write read_only readback", 3, int'(rd));
    check_value("led_write read_only pins", 3, int'(led));
    finish_test("led_write");

    // new settings, checked on the first conversion that uses them
    reg_write(7'd8, 24'd12);
    reg_write(7'd12, 24'd6);
    cfg_len = 12;
    cfg_total = 6;
    wait_interrupt();
    wait_interrupt();
    // stall the next run-down so the latched counts stay put
    hold_cmpr = 1'b1;
    reg_read(7'd9, rd_up);
    reg_read(7'd10, rd_down);
    reg_read(7'd11, rd_rundown);
    hold_cmpr = 1'b0;
    check_value("conversion phase_sum", 6, int'(rd_up) + int'(rd_down));
    finish_test("conversion");

    assert (rd_rundown != '0)
    else
    begin
      $display("error count_check rundown expected nonzero actual %0d", rd_rundown);
      test_bad = 1'b1;
    end
    check_value("count_check up", lat_up, int'(rd_up));
    check_value("count_check down", lat_down, int'(rd_down));
    check_value("count_check rundown", lat_rundown, int'(rd_rundown));
    check_value("count_check sig_pin", 0, sig_clks);
    check_value("count_check cmpr_latch", 0, latch_clks);
    finish_test("count_check");

    // soft restore
    reg_write(7'd13, 24'd0);
    cfg_len = 20;
    cfg_total = 10;
    check_value("soft_restore pins", 5, int'(led));
    reg_read(7'd7, rd);
    check_value("soft_restore led", 5, int'(rd));
    reg_read(7'd8, rd);
    check_value("soft_restore runup_len", 20, int'(rd));
    reg_read(7'd12, rd);
    check_value("soft_restore phases", 10, int'(rd));
    finish_test("soft_restore");

    // frame cut after 20 bits writes nothing
    // restore frame first, its low bits would then decode as a led write
    // of 0 if the cut frame were taken
    reg_write(7'd13, 24'h000070);
    spi_frame({1'b0, 7'd7, 24'd6}, 20, rd);
    check_value("short_frame pins", 5, int'(led));
    reg_read(7'd7, rd);
    check_value("short_frame led", 5, int'(rd));
    finish_test("short_frame");

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+src
src/adc_pkg.sv
src/adc_ctrl_if.sv
src/spi_register_bank.sv
src/multislope_modulator.sv
src/adc_top.sv
verification/adc_props.sv
verification/tb_adc_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_adc_top

out=$(./obj_dir/Vtb_adc_top)
echo "$out"

echo "$out" | grep -q "ALL TESTS PASSED"
